// File: common/soc_defines.svh
`ifndef SOC_DEFINES_SVH
`define SOC_DEFINES_SVH

// bus widths
`define DATA_W 32
`define ADDR_W 30
`define SEL_W 4

// on-chip RAM, 1024 words at address zero
`define RAM_ADDR_BITS 10
`define RAM_BASE_HI 20'h00000

// device region in the top 64 KB
`define DEV_HI_BITS 16
`define DEV_BASE_HI 16'hFFFF
`define DEV_SLOT_BITS 8
`define REG_ADDR_W 6
`define BOARD_SLOT 2

// board I/O widths
`define SWITCH_W 8
`define LED_W 8
`define DISP_W 16
`define BTN_W 4

// bus reset hold after reset_i drops
`define RESET_STRETCH 16

`endif

// File: common/soc_pkg.sv
`include "soc_defines.svh"

package soc_pkg;

	// master to slave
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [`SEL_W-1:0] sel;
		logic [`ADDR_W-1:0] addr;
		logic [`DATA_W-1:0] data;
	} wb_req_t;

	// slave to master
	typedef struct packed {
		logic [`DATA_W-1:0] data;
		logic ack;
		logic err;
	} wb_rsp_t;

	// adapter to device slot
	typedef struct packed {
		logic cs;
		logic we;
		logic [`SEL_W-1:0] sel;
		logic [`REG_ADDR_W-1:0] reg_addr;
		logic [`DATA_W-1:0] data;
	} dev_req_t;

	typedef struct packed {
		logic [`DATA_W-1:0] data;
		logic ack;
	} dev_rsp_t;

	// bit 3 is l, bit 0 is d
	typedef struct packed {
		logic l;
		logic r;
		logic u;
		logic d;
	} btn_t;

	// board register word offsets
	typedef enum logic [`REG_ADDR_W-1:0] {
		REG_SWITCH = 6'd0,
		REG_LED = 6'd1,
		REG_DISP = 6'd2,
		REG_IRQ = 6'd3
	} board_reg_e;

	typedef enum logic [1:0] {
		REGION_RAM,
		REGION_DEV,
		REGION_NONE
	} region_e;

endpackage

// File: src/reset_stretch.sv
`timescale 1ns/100ps
`include "soc_defines.svh"

module reset_stretch (
	input logic clk_cpu,
	input logic reset_i,
	output logic bus_reset_o
);

	// counted power-on reset, drains one bit per cycle
	logic [`RESET_STRETCH-1:0] shift_q;

	always_ff @(posedge clk_cpu) begin
		if (reset_i) begin
			shift_q <= '1;
		end else begin
			shift_q <= {shift_q[`RESET_STRETCH-2:0], 1'b0};
		end
	end

	// reset_i itself covers the cycles before the first load
	assign bus_reset_o = reset_i | (|shift_q);

endmodule

// File: src/wb_region_decoder.sv
`timescale 1ns/100ps
`include "soc_defines.svh"

module wb_region_decoder (
	input logic clk_cpu,
	input logic bus_reset_i,
	input soc_pkg::wb_req_t m_req_i,
	output soc_pkg::wb_rsp_t m_rsp_o,
	output soc_pkg::wb_req_t ram_req_o,
	input soc_pkg::wb_rsp_t ram_rsp_i,
	output soc_pkg::wb_req_t dev_req_o,
	input soc_pkg::wb_rsp_t dev_rsp_i
);

	soc_pkg::region_e region;
	logic sel_ram;
	logic sel_dev;
	logic err_q;

	// classify on the upper address bits
	always_comb begin
		if (m_req_i.addr[`ADDR_W-1:`RAM_ADDR_BITS] == `RAM_BASE_HI) begin
			region = soc_pkg::REGION_RAM;
		end else if (m_req_i.addr[`ADDR_W-1:`ADDR_W-`DEV_HI_BITS] == `DEV_BASE_HI) begin
			region = soc_pkg::REGION_DEV;
		end else begin
			region = soc_pkg::REGION_NONE;
		end
	end

	assign sel_ram = (region == soc_pkg::REGION_RAM);
	assign sel_dev = (region == soc_pkg::REGION_DEV);

	// only the chosen slave sees cyc and stb
	always_comb begin
		ram_req_o = m_req_i;
		ram_req_o.cyc = m_req_i.cyc & sel_ram;
		ram_req_o.stb = m_req_i.stb & sel_ram;
		dev_req_o = m_req_i;
		dev_req_o.cyc = m_req_i.cyc & sel_dev;
		dev_req_o.stb = m_req_i.stb & sel_dev;
	end

	// unmapped address, one-cycle err pulse
	always_ff @(posedge clk_cpu) begin
		if (bus_reset_i) begin
			err_q <= 1'b0;
		end else begin
			err_q <= m_req_i.cyc & m_req_i.stb & (region == soc_pkg::REGION_NONE) & ~err_q;
		end
	end

	always_comb begin
		case (region)
			soc_pkg::REGION_RAM: m_rsp_o = ram_rsp_i;
			soc_pkg::REGION_DEV: m_rsp_o = dev_rsp_i;
			default: begin
				m_rsp_o.data = '0;
				m_rsp_o.ack = 1'b0;
				m_rsp_o.err = err_q;
			end
		endcase
	end

endmodule

// File: src/wb_ram.sv
`timescale 1ns/100ps
`include "soc_defines.svh"

module wb_ram (
	input logic clk_cpu,
	input logic bus_reset_i,
	input soc_pkg::wb_req_t req_i,
	output soc_pkg::wb_rsp_t rsp_o
);

	localparam int WORDS = 1 << `RAM_ADDR_BITS;

	logic [`DATA_W-1:0] mem [WORDS];
	logic [`RAM_ADDR_BITS-1:0] idx;
	logic [`DATA_W-1:0] rdata_q;
	logic hit;
	logic ack_q;

	assign idx = req_i.addr[`RAM_ADDR_BITS-1:0];
	assign hit = req_i.cyc & req_i.stb;

	// no second ack while the master still holds stb
	always_ff @(posedge clk_cpu) begin
		if (bus_reset_i) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= hit & ~ack_q;
		end
	end

	// read at the sampling edge, write at the edge closing the ack cycle
	always_ff @(posedge clk_cpu) begin
		if (hit && !ack_q) begin
			rdata_q <= mem[idx];
		end
		if (hit && ack_q && req_i.we) begin
			for (int b = 0; b < `SEL_W; b++) begin
				if (req_i.sel[b]) begin
					mem[idx][8*b +: 8] <= req_i.data[8*b +: 8];
				end
			end
		end
	end

	assign rsp_o.data = rdata_q;
	assign rsp_o.ack = ack_q;
	assign rsp_o.err = 1'b0;

endmodule

// File: dev/wb_dev_adapter.sv
`timescale 1ns/100ps
`include "soc_defines.svh"

module wb_dev_adapter (
	input logic clk_cpu,
	input logic bus_reset_i,
	input soc_pkg::wb_req_t req_i,
	output soc_pkg::wb_rsp_t rsp_o,
	output soc_pkg::dev_req_t board_req_o,
	input soc_pkg::dev_rsp_t board_rsp_i
);

	// word address bits inside the device region
	localparam int LOW_BITS = 32 - `DEV_HI_BITS - 2;
	localparam int SLOT_W = LOW_BITS - `REG_ADDR_W;

	logic [SLOT_W-1:0] slot;
	logic [`REG_ADDR_W-1:0] reg_off;
	logic busy;
	logic hit;
	logic err_q;
	soc_pkg::dev_req_t board_q;

	assign slot = req_i.addr[LOW_BITS-1:`REG_ADDR_W];
	assign reg_off = req_i.addr[`REG_ADDR_W-1:0];

	// a slot is busy for the cycle it answers
	assign busy = board_q.cs | err_q;
	assign hit = req_i.cyc & req_i.stb & ~busy;

	always_ff @(posedge clk_cpu) begin
		if (bus_reset_i) begin
			board_q.cs <= 1'b0;
			err_q <= 1'b0;
		end else begin
			board_q.cs <= hit & (slot == `BOARD_SLOT);
			err_q <= hit & (slot != `BOARD_SLOT);
		end
		if (hit) begin
			board_q.we <= req_i.we;
			board_q.sel <= req_i.sel;
			board_q.reg_addr <= reg_off;
			board_q.data <= req_i.data;
		end
	end

	assign board_req_o = board_q;

	assign rsp_o.data = board_rsp_i.ack ? board_rsp_i.data : '0;
	assign rsp_o.ack = board_rsp_i.ack;
	assign rsp_o.err = err_q;

endmodule

// File: board/wb_board.sv
`timescale 1ns/100ps
`include "soc_defines.svh"

module wb_board (
	input logic clk_cpu,
	input logic bus_reset_i,
	input soc_pkg::dev_req_t req_i,
	output soc_pkg::dev_rsp_t rsp_o,
	input logic [`SWITCH_W-1:0] switch_i,
	input soc_pkg::btn_t btn_i,
	output logic [`LED_W-1:0] led_o,
	output logic [`DISP_W-1:0] disp_o,
	output logic irq_o
);

	logic [`SWITCH_W-1:0] sw_q;
	logic [`LED_W-1:0] led_q;
	logic [`DISP_W-1:0] disp_q;
	soc_pkg::btn_t btn_q;
	soc_pkg::btn_t btn_prev_q;
	logic [`BTN_W-1:0] irq_q;
	logic [`BTN_W-1:0] rise;
	logic [`BTN_W-1:0] clr;
	logic wr;
	logic [`DATA_W-1:0] rdata;

	assign wr = req_i.cs & req_i.we;
	assign rise = btn_q & ~btn_prev_q;

	// write-one-to-clear on the low byte
	always_comb begin
		clr = '0;
		if (wr && req_i.reg_addr == soc_pkg::REG_IRQ && req_i.sel[0]) begin
			clr = req_i.data[`BTN_W-1:0];
		end
	end

	always_ff @(posedge clk_cpu) begin
		sw_q <= switch_i;
	end

	always_ff @(posedge clk_cpu) begin
		if (bus_reset_i) begin
			led_q <= '0;
			disp_q <= '0;
			btn_q <= '0;
			btn_prev_q <= '0;
			irq_q <= '0;
		end else begin
			btn_q <= btn_i;
			btn_prev_q <= btn_q;
			// a new press wins over a clear in the same cycle
			irq_q <= (irq_q & ~clr) | rise;
			if (wr && req_i.reg_addr == soc_pkg::REG_LED && req_i.sel[0]) begin
				led_q <= req_i.data[`LED_W-1:0];
			end
			if (wr && req_i.reg_addr == soc_pkg::REG_DISP) begin
				if (req_i.sel[0]) begin
					disp_q[7:0] <= req_i.data[7:0];
				end
				if (req_i.sel[1]) begin
					disp_q[15:8] <= req_i.data[15:8];
				end
			end
		end
	end

	// read mux, unused offsets read zero
	always_comb begin
		rdata = '0;
		case (req_i.reg_addr)
			soc_pkg::REG_SWITCH: rdata[`SWITCH_W-1:0] = sw_q;
			soc_pkg::REG_LED: rdata[`LED_W-1:0] = led_q;
			soc_pkg::REG_DISP: rdata[`DISP_W-1:0] = disp_q;
			soc_pkg::REG_IRQ: rdata[`BTN_W-1:0] = irq_q;
			default: rdata = '0;
		endcase
	end

	assign rsp_o.data = rdata;
	assign rsp_o.ack = req_i.cs;

	assign led_o = led_q;
	assign disp_o = disp_q;
	assign irq_o = |irq_q;

endmodule

// File: src/soc_top.sv
`timescale 1ns/100ps
`include "soc_defines.svh"

module soc_top (
	input logic clk_cpu,
	input logic reset_i,
	input soc_pkg::wb_req_t bus_req_i,
	output soc_pkg::wb_rsp_t bus_rsp_o,
	input logic [`SWITCH_W-1:0] switch_i,
	input soc_pkg::btn_t btn_i,
	output logic [`LED_W-1:0] led_o,
	output logic [`DISP_W-1:0] disp_o,
	output logic irq_o
);

	logic bus_reset;

	soc_pkg::wb_req_t ram_req;
	soc_pkg::wb_rsp_t ram_rsp;
	soc_pkg::wb_req_t dev_req;
	soc_pkg::wb_rsp_t dev_rsp;

	soc_pkg::dev_req_t board_req;
	soc_pkg::dev_rsp_t board_rsp;

	reset_stretch u_reset_stretch (
		.clk_cpu(clk_cpu),
		.reset_i(reset_i),
		.bus_reset_o(bus_reset)
	);

	wb_region_decoder u_wb_region_decoder (
		.clk_cpu(clk_cpu),
		.bus_reset_i(bus_reset),
		.m_req_i(bus_req_i),
		.m_rsp_o(bus_rsp_o),
		.ram_req_o(ram_req),
		.ram_rsp_i(ram_rsp),
		.dev_req_o(dev_req),
		.dev_rsp_i(dev_rsp)
	);

	wb_ram u_wb_ram (
		.clk_cpu(clk_cpu),
		.bus_reset_i(bus_reset),
		.req_i(ram_req),
		.rsp_o(ram_rsp)
	);

	wb_dev_adapter u_wb_dev_adapter (
		.clk_cpu(clk_cpu),
		.bus_reset_i(bus_reset),
		.req_i(dev_req),
		.rsp_o(dev_rsp),
		.board_req_o(board_req),
		.board_rsp_i(board_rsp)
	);

	wb_board u_wb_board (
		.clk_cpu(clk_cpu),
		.bus_reset_i(bus_reset),
		.req_i(board_req),
		.rsp_o(board_rsp),
		.switch_i(switch_i),
		.btn_i(btn_i),
		.led_o(led_o),
		.disp_o(disp_o),
		.irq_o(irq_o)
	);

endmodule

// File: tb/tb_clock.sv
`timescale 1ns/100ps

module tb_clock #(
	parameter time PERIOD = 40ns
) (
	output logic clk_o
);

	initial begin
		clk_o = 1'b0;
	end

	always #(PERIOD / 2) clk_o = ~clk_o;

endmodule

// File: tb/soc_assertions.sv
`timescale 1ns/100ps

module soc_assertions (
	input logic clk_cpu,
	input logic bus_reset_i,
	input soc_pkg::wb_req_t req_i,
	input soc_pkg::wb_rsp_t rsp_i
);

	logic resp;

	assign resp = rsp_i.ack | rsp_i.err;

	// ack and err are exclusive
	ack_err_excl: assert property (@(posedge clk_cpu) disable iff (bus_reset_i)
		!(rsp_i.ack && rsp_i.err))
		else $error("ack and err high together");

	// responses are single-cycle pulses
	resp_pulse: assert property (@(posedge clk_cpu) disable iff (bus_reset_i)
		resp |=> !resp)
		else $error("response held for two cycles");

	// fixed latency from a new strobe
	resp_latency: assert property (@(posedge clk_cpu) disable iff (bus_reset_i)
		$rose(req_i.cyc && req_i.stb) |=> resp)
		else $error("no response after strobe");

endmodule

bind wb_region_decoder soc_assertions u_soc_assertions (
	.clk_cpu(clk_cpu),
	.bus_reset_i(bus_reset_i),
	.req_i(m_req_i),
	.rsp_i(m_rsp_o)
);

// File: tb/soc_tb.sv
`timescale 1ns/100ps
`include "soc_defines.svh"

module soc_tb;

	localparam int MAX_CYCLES = 4000;
	localparam int RAM_TEST_WORDS = 64;
	localparam logic [`ADDR_W-1:0] BOARD_BASE = {16'hFFFF, 8'd2, 6'd0};
	localparam logic [`ADDR_W-1:0] SLOT5_BASE = {16'hFFFF, 8'd5, 6'd0};
	localparam logic [`ADDR_W-1:0] UNMAPPED = 30'h0001_0000;

	logic clk_cpu;
	logic reset_i;
	soc_pkg::wb_req_t bus_req;
	soc_pkg::wb_rsp_t bus_rsp;
	logic [`SWITCH_W-1:0] switch_in;
	soc_pkg::btn_t btn;
	logic [`LED_W-1:0] led;
	logic [`DISP_W-1:0] disp;
	logic irq;

	// reference model state
	logic [`DATA_W-1:0] ref_mem [1 << `RAM_ADDR_BITS];
	logic [`LED_W-1:0] ref_led;
	logic [`DISP_W-1:0] ref_disp;
	logic [`BTN_W-1:0] ref_irq;

	soc_pkg::wb_rsp_t exp_q[$];
	soc_pkg::wb_rsp_t act_q[$];
	logic rd_q[$];
	string name_q[$];

	integer seed = 36;
	int cycles = 0;
	logic [5:0] widx;

	tb_clock #(.PERIOD(40ns)) u_tb_clock (.clk_o(clk_cpu));

	soc_top u_soc_top (
		.clk_cpu(clk_cpu),
		.reset_i(reset_i),
		.bus_req_i(bus_req),
		.bus_rsp_o(bus_rsp),
		.switch_i(switch_in),
		.btn_i(btn),
		.led_o(led),
		.disp_o(disp),
		.irq_o(irq)
	);

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("TEST FAILED");
		$fatal(1);
	endtask

	// expected response from the address map and the model registers
	function automatic soc_pkg::wb_rsp_t ref_rsp(input soc_pkg::wb_req_t req);
		soc_pkg::wb_rsp_t r;
		r = '0;
		if (req.addr[29:10] == 20'd0) begin
			r.ack = 1'b1;
			if (!req.we) r.data = ref_mem[req.addr[9:0]];
		end else if (req.addr[29:14] == 16'hFFFF && req.addr[13:6] == 8'd2) begin
			r.ack = 1'b1;
			if (!req.we) begin
				case (req.addr[5:0])
					soc_pkg::REG_SWITCH: r.data = {24'd0, switch_in};
					soc_pkg::REG_LED: r.data = {24'd0, ref_led};
					soc_pkg::REG_DISP: r.data = {16'd0, ref_disp};
					soc_pkg::REG_IRQ: r.data = {28'd0, ref_irq};
					default: r.data = '0;
				endcase
			end
		end else begin
			r.err = 1'b1;
		end
		return r;
	endfunction

	task automatic model_write(input soc_pkg::wb_req_t req);
		for (int b = 0; b < 4; b++) begin
			if (req.sel[b]) ref_mem[req.addr[9:0]][8*b +: 8] = req.data[8*b +: 8];
		end
	endtask

	task automatic model_board_write(input soc_pkg::wb_req_t req);
		if (req.addr[5:0] == soc_pkg::REG_LED && req.sel[0]) ref_led = req.data[7:0];
		if (req.addr[5:0] == soc_pkg::REG_DISP) begin
			if (req.sel[0]) ref_disp[7:0] = req.data[7:0];
			if (req.sel[1]) ref_disp[15:8] = req.data[15:8];
		end
		if (req.addr[5:0] == soc_pkg::REG_IRQ && req.sel[0]) ref_irq = ref_irq & ~req.data[3:0];
	endtask

	// error reads must return zero data
	task automatic check_rsp(input string name, input soc_pkg::wb_rsp_t exp,
			input soc_pkg::wb_rsp_t act, input logic rd);
		if (act.ack !== exp.ack || act.err !== exp.err ||
				(rd && act.data !== exp.data)) begin
			$display("error %s expected %h actual %h", name, exp, act);
			fail_run("bus response mismatch");
		end
	endtask

	task automatic check_led(input string name, input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp) begin
			$display("error %s expected %h actual %h", name, exp, act);
			fail_run("led output mismatch");
		end
	endtask

	task automatic check_disp(input string name, input logic [15:0] exp, input logic [15:0] act);
		if (act !== exp) begin
			$display("error %s expected %h actual %h", name, exp, act);
			fail_run("display output mismatch");
		end
	endtask

	task automatic check_irq(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("error %s expected %h actual %h", name, exp, act);
			fail_run("interrupt output mismatch");
		end
	endtask

	// one transfer, entered and left on a falling edge
	task automatic access(input string name, input logic we, input logic [3:0] sel,
			input logic [`ADDR_W-1:0] addr, input logic [`DATA_W-1:0] data);
		soc_pkg::wb_req_t req;
		soc_pkg::wb_rsp_t exp;
		int n;
		req = '{cyc: 1'b1, stb: 1'b1, we: we, sel: sel, addr: addr, data: data};
		exp = ref_rsp(req);
		bus_req = req;
		n = 0;
		do begin
			@(negedge clk_cpu);
			n++;
		end while (!(bus_rsp.ack || bus_rsp.err) && n < 3);
		if (!(bus_rsp.ack || bus_rsp.err)) fail_run({"no bus response in ", name});
		if (n != 1) fail_run({"bus response late in ", name});
		exp_q.push_back(exp);
		act_q.push_back(bus_rsp);
		rd_q.push_back(!we);
		name_q.push_back(name);
		if (we && exp.ack && addr[29:10] == 20'd0) model_write(req);
		if (we && exp.ack && addr[29:10] != 20'd0) model_board_write(req);
		@(negedge clk_cpu);
		bus_req.cyc = 1'b0;
		bus_req.stb = 1'b0;
		@(negedge clk_cpu);
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(negedge clk_cpu);
	endtask

	// compare process
	always @(negedge clk_cpu) begin
		while (exp_q.size() > 0) begin
			check_rsp(name_q.pop_front(), exp_q.pop_front(), act_q.pop_front(), rd_q.pop_front());
		end
	end

	always @(posedge clk_cpu) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) fail_run("timeout, the test did not finish in time");
	end

	initial begin
		reset_i = 1'b1;
		bus_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, sel: 4'hF, addr: '0, data: '0};
		switch_in = '0;
		btn = '0;
		ref_led = '0;
		ref_disp = '0;
		ref_irq = '0;

		// request held through reset and the stretch
		for (int i = 0; i < 3 + `RESET_STRETCH; i++) begin
			@(negedge clk_cpu);
			if (bus_rsp.ack || bus_rsp.err) fail_run("bus answered during reset");
			check_led("reset_led", 8'd0, led);
			check_disp("reset_disp", 16'd0, disp);
			check_irq("reset_irq", 1'b0, irq);
			if (i == 2) begin
				reset_i = 1'b0;
			end
		end
		bus_req = '0;
		wait_cycles(4);

		// RAM fill, random merges, readback
		for (int i = 0; i < RAM_TEST_WORDS; i++) begin
			access("ram_fill", 1'b1, 4'hF, 30'(i), $random(seed));
		end
		for (int i = 0; i < 200; i++) begin
			widx = 6'($random(seed));
			access("ram_merge", 1'b1, 4'($random(seed)), 30'(widx), $random(seed));
		end
		for (int i = 0; i < RAM_TEST_WORDS; i++) begin
			access("ram_read", 1'b0, 4'hF, 30'(i), '0);
		end

		// board registers
		access("led_write", 1'b1, 4'hF, BOARD_BASE + soc_pkg::REG_LED, 32'h0000_00A5);
		check_led("led_out", ref_led, led);
		access("led_read", 1'b0, 4'hF, BOARD_BASE + soc_pkg::REG_LED, '0);
		access("disp_write", 1'b1, 4'hF, BOARD_BASE + soc_pkg::REG_DISP, 32'h0000_1234);
		access("disp_byte", 1'b1, 4'h2, BOARD_BASE + soc_pkg::REG_DISP, 32'h0000_BE00);
		check_disp("disp_out", ref_disp, disp);
		access("disp_read", 1'b0, 4'hF, BOARD_BASE + soc_pkg::REG_DISP, '0);
		switch_in = 8'($random(seed));
		wait_cycles(2);
		access("switch_read", 1'b0, 4'hF, BOARD_BASE + soc_pkg::REG_SWITCH, '0);

		// button presses and write-one-to-clear
		btn.u = 1'b1;
		wait_cycles(1);
		check_irq("irq_not_yet", 1'b0, irq);
		wait_cycles(1);
		ref_irq[1] = 1'b1;
		check_irq("irq_press", 1'b1, irq);
		btn.l = 1'b1;
		wait_cycles(4);
		ref_irq[3] = 1'b1;
		btn = '0;
		access("irq_read", 1'b0, 4'hF, BOARD_BASE + soc_pkg::REG_IRQ, '0);
		access("irq_clear_u", 1'b1, 4'hF, BOARD_BASE + soc_pkg::REG_IRQ, 32'h2);
		access("irq_keep_l", 1'b0, 4'hF, BOARD_BASE + soc_pkg::REG_IRQ, '0);
		check_irq("irq_still", 1'b1, irq);
		access("irq_clear_l", 1'b1, 4'hF, BOARD_BASE + soc_pkg::REG_IRQ, 32'h8);
		check_irq("irq_cleared", 1'b0, irq);

		// unmapped region and empty slot
		access("unmapped_write", 1'b1, 4'hF, UNMAPPED, 32'hDEAD_BEEF);
		access("unmapped_read", 1'b0, 4'hF, UNMAPPED, '0);
		access("slot5_write", 1'b1, 4'hF, SLOT5_BASE + soc_pkg::REG_LED, 32'hFF);
		access("slot5_read", 1'b0, 4'hF, SLOT5_BASE + soc_pkg::REG_DISP, '0);
		access("ram_intact", 1'b0, 4'hF, 30'd0, '0);
		access("led_intact", 1'b0, 4'hF, BOARD_BASE + soc_pkg::REG_LED, '0);
		check_led("led_unchanged", ref_led, led);
		check_disp("disp_unchanged", ref_disp, disp);

		wait_cycles(2);
		if (exp_q.size() == 0) begin
			$display("TEST OK");
		end else begin
			fail_run("responses left unchecked");
		end
		$finish;
	end

endmodule

// File: soc_top.f
+incdir+common
common/soc_pkg.sv
src/reset_stretch.sv
src/wb_region_decoder.sv
src/wb_ram.sv
dev/wb_dev_adapter.sv
board/wb_board.sv
src/soc_top.sv
tb/tb_clock.sv
tb/soc_assertions.sv
tb/soc_tb.sv

// File: run.sh
#!/bin/sh
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f soc_top.f --top-module soc_tb -Mdir obj_dir

./obj_dir/Vsoc_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAILED" sim.log; then
	exit 1
fi
if ! grep -q "TEST OK" sim.log; then
	exit 1
fi
exit 0
